// File: Bender.yml
package:
  name: joy_io

sources:
  - joy_pkg.sv
  - joy_regs.sv
  - joy_tx_queue.sv
  - joy_serial.sv
  - joy_io_top.sv
  - target: test
    files:
      - tb_joy_pad.sv
      - tb_joy_io.sv

// File: joy_io.f
joy_pkg.sv
joy_regs.sv
joy_tx_queue.sv
joy_serial.sv
joy_io_top.sv
tb_joy_pad.sv
tb_joy_io.sv

// File: joy_io_top.sv
// Top level joining register block, transmit queue and serial engine
`timescale 1ns/1ps

module joy_io_top #(
	parameter int TXQ_DEPTH = 4,
	parameter int TIMER_W   = 21
) (
	input  logic              i_clk,
	input  logic              i_resetACK,
	input  joy_pkg::joy_bus_t i_bus,
	output logic [31:0]       o_rdata,
	output logic              o_int7,
	output logic              o_bad_access,
	output logic              o_port_clk,
	output logic [1:0]        o_port_sel,
	output logic              o_port_txd,
	input  logic [1:0]        i_port_rxd
);

	// --------------------------------------------------------------------------
	// Interconnect
	// --------------------------------------------------------------------------
	logic                  tx_req;
	logic                  tx_ack;
	joy_pkg::joy_tx_item_t tx_item;
	logic                  q_req;
	logic                  q_ack;
	joy_pkg::joy_tx_item_t q_item;
	logic                  rx_req;
	logic                  rx_ack;
	logic [7:0]            rx_data;
	joy_pkg::joy_mode_t    mode;
	logic [15:0]           baud_reload;

	// CPU registers, producer of TX bytes
	joy_regs joy_regs_inst (
		.i_clk         (i_clk),
		.i_resetACK    (i_resetACK),
		.i_bus         (i_bus),
		.o_rdata       (o_rdata),
		.o_int7        (o_int7),
		.o_bad_access  (o_bad_access),
		.o_tx_req      (tx_req),
		.o_tx_item     (tx_item),
		.i_tx_ack      (tx_ack),
		.i_rx_req      (rx_req),
		.i_rx_data     (rx_data),
		.o_rx_ack      (rx_ack),
		.o_mode        (mode),
		.o_baud_reload (baud_reload)
	);

	joy_tx_queue #(
		.TXQ_DEPTH (TXQ_DEPTH)
	) joy_tx_queue_inst (
		.i_clk       (i_clk),
		.i_resetACK  (i_resetACK),
		.i_push_req  (tx_req),
		.i_push_item (tx_item),
		.o_push_ack  (tx_ack),
		.o_pop_req   (q_req),
		.o_pop_item  (q_item),
		.i_pop_ack   (q_ack)
	);

	// Consumer, drives the port pins
	joy_serial #(
		.TIMER_W (TIMER_W)
	) joy_serial_inst (
		.i_clk         (i_clk),
		.i_resetACK    (i_resetACK),
		.i_mode        (mode),
		.i_baud_reload (baud_reload),
		.i_q_req       (q_req),
		.i_q_item      (q_item),
		.o_q_ack       (q_ack),
		.o_rx_req      (rx_req),
		.o_rx_data     (rx_data),
		.i_rx_ack      (rx_ack),
		.o_port_clk    (o_port_clk),
		.o_port_sel    (o_port_sel),
		.o_port_txd    (o_port_txd),
		.i_port_rxd    (i_port_rxd)
	);

endmodule

// File: joy_pkg.sv
// Access-width and register-offset enums, CPU bus, mode, control and queue-item structs
package joy_pkg;

	// --------------------------------------------------------------------------
	// Enums
	// --------------------------------------------------------------------------

	// Width of one CPU access
	typedef enum logic [1:0] {
		access_8bit  = 2'd0,
		access_16bit = 2'd1,
		access_32bit = 2'd2,
		access_undef = 2'd3
	} joy_access_e;

	// Register offset as 16-bit word index in the window
	typedef enum logic [2:0] {
		reg_tx_rx_data = 3'd0, // TX data on write, RX data on read
		reg_stat       = 3'd2, // Read only
		reg_mode       = 3'd4,
		reg_ctrl       = 3'd5,
		reg_baud       = 3'd7  // Reload value
	} joy_reg_e;

	// --------------------------------------------------------------------------
	// Structs
	// --------------------------------------------------------------------------

	// One CPU access, 41 bits
	typedef struct packed {
		logic        cs;    // Chip select
		logic        rd;
		logic        wr;
		logic [3:0]  addr;  // Byte address in window
		joy_access_e width;
		logic [31:0] wdata;
	} joy_bus_t;

	// JOY_MODE fields, 7 bits
	typedef struct packed {
		logic       clk_pol;     // Bit 8, read back only
		logic       parity_odd;  // Bit 5
		logic       parity_en;   // Bit 4
		logic [1:0] char_len;    // Bits 3..2
		logic [1:0] reload_fact; // Bits 1..0, 0 and 1 both mean x1
	} joy_mode_t;

	// JOY_CTRL fields, 11 bits
	// Bits 4 and 6 act on write only and are not stored
	typedef struct packed {
		logic       slot;        // Bit 13
		logic       ack_int_en;  // Bit 12
		logic       rx_int_en;   // Bit 11
		logic       tx_int_en;   // Bit 10
		logic [1:0] rx_int_mode; // Bits 9..8
		logic       bit5;
		logic       bit3;
		logic       rx_en;       // Bit 2
		logic       sel;         // Bit 1
		logic       tx_en;       // Bit 0
	} joy_ctrl_t;

	// Queued TX byte with its slot
	typedef struct packed {
		logic       slot;
		logic [7:0] data;
	} joy_tx_item_t;

endpackage

// File: joy_regs.sv
// CPU register block with access decode, MODE/CTRL/BAUD registers, TX push and RX history
`timescale 1ns/1ps

module joy_regs (
	input  logic                  i_clk,
	input  logic                  i_resetACK,
	input  joy_pkg::joy_bus_t     i_bus,
	output logic [31:0]           o_rdata,
	output logic                  o_int7,
	output logic                  o_bad_access,
	output logic                  o_tx_req,
	output joy_pkg::joy_tx_item_t o_tx_item,
	input  logic                  i_tx_ack,
	input  logic                  i_rx_req,
	input  logic [7:0]            i_rx_data,
	output logic                  o_rx_ack,
	output joy_pkg::joy_mode_t    o_mode,
	output logic [15:0]           o_baud_reload
);

	joy_pkg::joy_reg_e  word;          // Decoded register
	joy_pkg::joy_ctrl_t ctrl_q;
	logic [31:0]        rx_hist_q;     // Last four RX bytes, newest low
	logic               tx_finished_q; // STAT bit 2
	logic               rx_pending_q;  // STAT bit 1
	logic               irq_q;         // STAT bit 9, sticky
	logic [31:0]        rd_mux;

	logic wr;
	logic rd;
	logic bad_access;
	logic ctrl_wr;
	logic ctrl_reset;
	logic ack_clear;
	logic tx_ready;
	logic tx_accept;
	logic rx_take;

	// --------------------------------------------------------------------------
	// Access decode
	// --------------------------------------------------------------------------
	assign word = joy_pkg::joy_reg_e'(i_bus.addr[3:1]);
	assign wr   = i_bus.cs && i_bus.wr;
	assign rd   = i_bus.cs && i_bus.rd;

	// Forbidden offsets and widths
	assign bad_access = i_bus.cs && (
		(i_bus.addr[3:1] == 3'd1) ||
		(i_bus.addr[3:1] == 3'd3) ||
		(((word == joy_pkg::reg_mode) || (word == joy_pkg::reg_ctrl)) &&
		 (i_bus.width == joy_pkg::access_32bit)) ||
		((i_bus.width == joy_pkg::access_8bit) && (i_bus.addr != 4'd0)));

	assign ctrl_wr    = wr && (word == joy_pkg::reg_ctrl);
	assign ack_clear  = ctrl_wr && i_bus.wdata[4]; // Clears IRQ
	assign ctrl_reset = ctrl_wr && i_bus.wdata[6]; // Soft reset of registers

	// No push in flight on either wire
	assign tx_ready = !o_tx_req && !i_tx_ack;

	// TX byte taken only at 32 bit, unselected and enabled
	assign tx_accept = wr && (word == joy_pkg::reg_tx_rx_data) &&
		(i_bus.width == joy_pkg::access_32bit) &&
		!ctrl_q.sel && ctrl_q.tx_en && tx_ready;

	assign rx_take = i_rx_req && !o_rx_ack; // New byte from serial engine

	// --------------------------------------------------------------------------
	// Handshakes towards queue and serial engine
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetACK) begin
			o_tx_req <= 1'b0;
			o_rx_ack <= 1'b0;
		end else begin
			if (tx_accept) begin
				o_tx_req <= 1'b1;
			end else if (o_tx_req && i_tx_ack) begin
				o_tx_req <= 1'b0; // Queue has it
			end
			if (rx_take) begin
				o_rx_ack <= 1'b1;
			end else if (!i_rx_req) begin
				o_rx_ack <= 1'b0;
			end
		end
	end

	// Item stays stable while req is high
	always_ff @(posedge i_clk) begin
		if (tx_accept) begin
			o_tx_item.slot <= ctrl_q.slot;
			o_tx_item.data <= i_bus.wdata[7:0];
		end
	end

	// --------------------------------------------------------------------------
	// Registers
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetACK || ctrl_reset) begin
			o_mode        <= '0;
			ctrl_q        <= '0;
			o_baud_reload <= 16'd0;
			rx_hist_q     <= 32'd0;
			tx_finished_q <= 1'b0;
			rx_pending_q  <= 1'b0;
			irq_q         <= 1'b0;
			o_bad_access  <= 1'b0;
		end else begin
			if (bad_access) begin
				o_bad_access <= 1'b1; // Sticky
			end

			if (wr) begin
				case (word)
					joy_pkg::reg_mode: begin
						o_mode.reload_fact <= i_bus.wdata[1:0];
						o_mode.char_len    <= i_bus.wdata[3:2];
						o_mode.parity_en   <= i_bus.wdata[4];
						o_mode.parity_odd  <= i_bus.wdata[5];
						o_mode.clk_pol     <= i_bus.wdata[8];
					end
					joy_pkg::reg_ctrl: begin
						ctrl_q.tx_en       <= i_bus.wdata[0];
						ctrl_q.sel         <= i_bus.wdata[1];
						ctrl_q.rx_en       <= i_bus.wdata[2];
						ctrl_q.bit3        <= i_bus.wdata[3];
						ctrl_q.bit5        <= i_bus.wdata[5];
						ctrl_q.rx_int_mode <= i_bus.wdata[9:8];
						ctrl_q.tx_int_en   <= i_bus.wdata[10];
						ctrl_q.rx_int_en   <= i_bus.wdata[11];
						ctrl_q.ack_int_en  <= i_bus.wdata[12];
						ctrl_q.slot        <= i_bus.wdata[13];
					end
					joy_pkg::reg_baud: o_baud_reload <= i_bus.wdata[15:0];
					default: ;
				endcase
			end

			if (tx_accept) begin
				tx_finished_q <= 1'b0; // New transfer under way
			end
			if (ack_clear) begin
				irq_q <= 1'b0;
			end
			if (rd && (word == joy_pkg::reg_tx_rx_data)) begin
				rx_pending_q <= 1'b0;
			end

			// End of transfer, a new event wins over a clear
			if (rx_take) begin
				rx_hist_q     <= {rx_hist_q[23:0], i_rx_data};
				tx_finished_q <= 1'b1;
				rx_pending_q  <= 1'b1;
				if (ctrl_q.tx_int_en) begin
					irq_q <= 1'b1;
				end
			end
		end
	end

	assign o_int7 = irq_q;

	// --------------------------------------------------------------------------
	// Read mux, registered one cycle
	// --------------------------------------------------------------------------
	always_comb begin
		rd_mux = 32'd0;
		case (word)
			joy_pkg::reg_tx_rx_data: rd_mux = rx_hist_q;
			joy_pkg::reg_stat: begin
				rd_mux[0] = tx_ready;
				rd_mux[1] = rx_pending_q;
				rd_mux[2] = tx_finished_q;
				rd_mux[9] = irq_q;
			end
			joy_pkg::reg_mode: begin
				rd_mux[1:0] = o_mode.reload_fact;
				rd_mux[3:2] = o_mode.char_len;
				rd_mux[4]   = o_mode.parity_en;
				rd_mux[5]   = o_mode.parity_odd;
				rd_mux[8]   = o_mode.clk_pol;
			end
			joy_pkg::reg_ctrl: begin
				rd_mux[0]   = ctrl_q.tx_en;
				rd_mux[1]   = ctrl_q.sel;
				rd_mux[2]   = ctrl_q.rx_en;
				rd_mux[3]   = ctrl_q.bit3;
				rd_mux[5]   = ctrl_q.bit5;
				rd_mux[9:8] = ctrl_q.rx_int_mode;
				rd_mux[10]  = ctrl_q.tx_int_en;
				rd_mux[11]  = ctrl_q.rx_int_en;
				rd_mux[12]  = ctrl_q.ack_int_en;
				rd_mux[13]  = ctrl_q.slot;
			end
			joy_pkg::reg_baud: rd_mux[15:0] = o_baud_reload;
			default: ;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (rd) begin
			o_rdata <= rd_mux; // Valid the cycle after the access
		end
	end

endmodule

// File: joy_serial.sv
// Baud timer and byte shift engine for the two controller slots
`timescale 1ns/1ps

module joy_serial #(
	parameter int TIMER_W = 21
) (
	input  logic                  i_clk,
	input  logic                  i_resetACK,
	input  joy_pkg::joy_mode_t    i_mode,
	input  logic [15:0]           i_baud_reload,
	input  logic                  i_q_req,
	input  joy_pkg::joy_tx_item_t i_q_item,
	output logic                  o_q_ack,
	output logic                  o_rx_req,
	output logic [7:0]            o_rx_data,
	input  logic                  i_rx_ack,
	output logic                  o_port_clk,
	output logic [1:0]            o_port_sel,
	output logic                  o_port_txd,
	input  logic [1:0]            i_port_rxd
);

	localparam int PROD_W = TIMER_W + 1;

	typedef enum logic [2:0] {
		st_idle,   // Wait for queue item
		st_latch,  // Close pop handshake, align to tick
		st_low,    // Port clock low, bit driven
		st_high,   // Port clock high, bit sampled
		st_return  // Hand RX byte back
	} state_e;

	state_e             state_q;
	logic [PROD_W-1:0]  product;     // Reload times factor
	logic [TIMER_W-1:0] half_period;
	logic [TIMER_W-1:0] half_q;      // Last applied half period
	logic [TIMER_W-1:0] timer_q;
	logic               tick;
	logic [7:0]         tx_sh_q;
	logic [7:0]         rx_sh_q;
	logic               slot_q;
	logic [2:0]         bit_q;

	// --------------------------------------------------------------------------
	// Baud timer
	// --------------------------------------------------------------------------
	always_comb begin
		case (i_mode.reload_fact)
			2'd2:    product = PROD_W'(i_baud_reload) << 4; // x16
			2'd3:    product = PROD_W'(i_baud_reload) << 6; // x64
			default: product = PROD_W'(i_baud_reload);
		endcase
		half_period = product[PROD_W-1:1];
		if (half_period == '0) begin
			half_period = TIMER_W'(1); // Never below one cycle
		end
	end

	assign tick = (timer_q == '0); // One per half period

	// Free running, a new reload value or factor restarts it
	always_ff @(posedge i_clk) begin
		if (i_resetACK) begin
			timer_q <= '0;
			half_q  <= '0;
		end else begin
			half_q <= half_period;
			if (tick || (half_period != half_q)) begin
				timer_q <= half_period - 1'b1;
			end else begin
				timer_q <= timer_q - 1'b1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Shift engine
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetACK) begin
			state_q    <= st_idle;
			o_q_ack    <= 1'b0;
			o_rx_req   <= 1'b0;
			o_port_clk <= 1'b1; // Idles high
			o_port_sel <= 2'b00;
			o_port_txd <= 1'b1;
			bit_q      <= 3'd0;
		end else begin
			case (state_q)
				st_idle: begin
					if (i_q_req) begin
						tx_sh_q <= i_q_item.data;
						slot_q  <= i_q_item.slot;
						o_q_ack <= 1'b1;
						state_q <= st_latch;
					end
				end
				st_latch: begin
					if (!i_q_req) begin
						o_q_ack <= 1'b0;
					end
					if (!o_q_ack && tick) begin
						o_port_sel <= 2'b01 << slot_q;
						o_port_clk <= 1'b0;
						o_port_txd <= tx_sh_q[0];        // Bit 0 on first fall
						tx_sh_q    <= {1'b0, tx_sh_q[7:1]};
						bit_q      <= 3'd0;
						state_q    <= st_low;
					end
				end
				st_low: begin
					if (tick) begin
						o_port_clk <= 1'b1;
						rx_sh_q    <= {i_port_rxd[slot_q], rx_sh_q[7:1]}; // LSB first
						state_q    <= st_high;
					end
				end
				st_high: begin
					if (tick) begin
						if (bit_q == 3'd7) begin
							// Eight bits done
							o_port_sel <= 2'b00;
							o_port_txd <= 1'b1;
							o_rx_req   <= 1'b1;
							state_q    <= st_return;
						end else begin
							o_port_clk <= 1'b0;
							o_port_txd <= tx_sh_q[0];
							tx_sh_q    <= {1'b0, tx_sh_q[7:1]};
							bit_q      <= bit_q + 3'd1;
							state_q    <= st_low;
						end
					end
				end
				st_return: begin
					if (o_rx_req && i_rx_ack) begin
						o_rx_req <= 1'b0;
					end
					if (!o_rx_req && !i_rx_ack) begin
						state_q <= st_idle; // Return handshake closed
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	assign o_rx_data = rx_sh_q; // Stable while rx_req is high

endmodule

// File: joy_tx_queue.sv
// Transmit FIFO with four-phase push and pop handshakes
`timescale 1ns/1ps

module joy_tx_queue #(
	parameter int TXQ_DEPTH = 4 // Power of two
) (
	input  logic                  i_clk,
	input  logic                  i_resetACK,
	input  logic                  i_push_req,
	input  joy_pkg::joy_tx_item_t i_push_item,
	output logic                  o_push_ack,
	output logic                  o_pop_req,
	output joy_pkg::joy_tx_item_t o_pop_item,
	input  logic                  i_pop_ack
);

	localparam int PTR_W = $clog2(TXQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	joy_pkg::joy_tx_item_t mem [TXQ_DEPTH];
	logic [PTR_W-1:0]      wr_ptr_q;
	logic [PTR_W-1:0]      rd_ptr_q;
	logic [CNT_W-1:0]      count_q;
	logic                  push_do;
	logic                  pop_do;

	// Store on a fresh req with room left, stall when full
	assign push_do = i_push_req && !o_push_ack && (count_q != CNT_W'(TXQ_DEPTH));
	assign pop_do  = o_pop_req && i_pop_ack; // Engine latched head

	assign o_pop_item = mem[rd_ptr_q];

	always_ff @(posedge i_clk) begin
		if (push_do) begin
			mem[wr_ptr_q] <= i_push_item;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_resetACK) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			o_push_ack <= 1'b0;
			o_pop_req  <= 1'b0;
		end else begin
			// Push side
			if (push_do) begin
				wr_ptr_q   <= wr_ptr_q + 1'b1; // Wraps at depth
				o_push_ack <= 1'b1;
			end else if (!i_push_req) begin
				o_push_ack <= 1'b0;
			end

			// Pop side, next req only after ack is back low
			if (pop_do) begin
				rd_ptr_q  <= rd_ptr_q + 1'b1;
				o_pop_req <= 1'b0;
			end else if (!o_pop_req && !i_pop_ack && (count_q != '0)) begin
				o_pop_req <= 1'b1;
			end

			count_q <= count_q + CNT_W'(push_do) - CNT_W'(pop_do);
		end
	end

endmodule

// File: tb_joy_io.sv
// Testbench top with clock, reset, random CPU accesses, reference model and compare tasks
`timescale 1ns/1ps

module tb_joy_io;

	localparam int          TXQ_DEPTH  = 4;
	localparam int          TIMER_W    = 21;
	localparam logic [31:0] SEED       = 32'h28e783ad;
	localparam logic [31:0] MODE_MASK  = 32'h0000_013F; // Bits 0..5 and 8
	localparam logic [31:0] CTRL_MASK  = 32'h0000_3F2F; // Bits 0..3, 5, 8..13
	localparam int          POLL_LIMIT = 4000;

	logic              clk;
	logic              rst;
	joy_pkg::joy_bus_t bus;
	logic [31:0]       rdata;
	logic              int7;
	logic              bad;
	logic              port_clk;
	logic [1:0]        port_sel;
	logic              port_txd;
	logic [1:0]        port_rxd;
	int                pad_count;

	// Reference model state
	logic [31:0]           mode_w;
	logic [31:0]           ctrl_w;
	logic [15:0]           baud_w;
	logic [31:0]           hist_m;   // Four newest answers, newest low
	logic                  irq_m;
	logic                  bad_m;
	logic                  fin_m;
	logic                  pend_m;
	joy_pkg::joy_tx_item_t exp_q[$]; // Bytes expected on the port
	int                    seen;     // Pad bytes already checked
	int unsigned           seed_val;
	logic [31:0]           w;

	joy_io_top #(
		.TXQ_DEPTH (TXQ_DEPTH),
		.TIMER_W   (TIMER_W)
	) joy_io_top_inst (
		.i_clk        (clk),
		.i_resetACK   (rst),
		.i_bus        (bus),
		.o_rdata      (rdata),
		.o_int7       (int7),
		.o_bad_access (bad),
		.o_port_clk   (port_clk),
		.o_port_sel   (port_sel),
		.o_port_txd   (port_txd),
		.i_port_rxd   (port_rxd)
	);

	tb_joy_pad pad_inst (
		.i_port_clk (port_clk),
		.i_port_sel (port_sel),
		.i_port_txd (port_txd),
		.o_port_rxd (port_rxd),
		.o_count    (pad_count)
	);

	always #2 clk = ~clk; // 4 ns period

	// ------------------------------------------------------------------------
	// Failure and compare tasks
	// ------------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_mode(input string name, input joy_pkg::joy_mode_t got,
		input joy_pkg::joy_mode_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ctrl(input string name, input joy_pkg::joy_ctrl_t got,
		input joy_pkg::joy_ctrl_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
		end
	endtask

	// Field layout of JOY_MODE and JOY_CTRL as seen by the CPU
	function automatic joy_pkg::joy_mode_t mode_from_word(input logic [31:0] v);
		joy_pkg::joy_mode_t m;
		m.reload_fact = v[1:0];
		m.char_len    = v[3:2];
		m.parity_en   = v[4];
		m.parity_odd  = v[5];
		m.clk_pol     = v[8];
		return m;
	endfunction

	function automatic joy_pkg::joy_ctrl_t ctrl_from_word(input logic [31:0] v);
		joy_pkg::joy_ctrl_t c;
		c.tx_en       = v[0];
		c.sel         = v[1];
		c.rx_en       = v[2];
		c.bit3        = v[3];
		c.bit5        = v[5];
		c.rx_int_mode = v[9:8];
		c.tx_int_en   = v[10];
		c.rx_int_en   = v[11];
		c.ack_int_en  = v[12];
		c.slot        = v[13];
		return c;
	endfunction

	// ------------------------------------------------------------------------
	// CPU bus access, one cycle per access
	// ------------------------------------------------------------------------
	task automatic drive_bus(input logic rd, input logic wr, input logic [3:0] addr,
		input joy_pkg::joy_access_e width, input logic [31:0] data);
		@(posedge clk);
		#1;
		bus       = '0;
		bus.cs    = 1'b1;
		bus.rd    = rd;
		bus.wr    = wr;
		bus.addr  = addr;
		bus.width = width;
		bus.wdata = data;
		@(posedge clk);
		#1;
		bus = '0; // Read data is valid here
	endtask

	task automatic bus_write(input logic [3:0] addr, input joy_pkg::joy_access_e width,
		input logic [31:0] data);
		drive_bus(1'b0, 1'b1, addr, width, data);
	endtask

	task automatic bus_read(input logic [3:0] addr, input joy_pkg::joy_access_e width,
		output logic [31:0] data);
		drive_bus(1'b1, 1'b0, addr, width, 32'h0);
		data = rdata;
	endtask

	task automatic model_reset();
		mode_w = 32'h0;
		ctrl_w = 32'h0;
		baud_w = 16'h0;
		hist_m = 32'h0;
		irq_m  = 1'b0;
		bad_m  = 1'b0;
		fin_m  = 1'b0;
		pend_m = 1'b0;
	endtask

	task automatic write_mode(input logic [31:0] v);
		bus_write(4'h8, joy_pkg::access_16bit, v);
		mode_w = v & MODE_MASK;
	endtask

	task automatic write_ctrl(input logic [31:0] v);
		bus_write(4'hA, joy_pkg::access_16bit, v);
		if (v[6]) begin
			model_reset(); // Soft reset, queue untouched
		end else begin
			ctrl_w = v & CTRL_MASK;
			if (v[4]) begin
				irq_m = 1'b0;
			end
		end
	endtask

	task automatic write_baud(input logic [31:0] v);
		bus_write(4'hE, joy_pkg::access_16bit, v);
		baud_w = v[15:0];
	endtask

	// Read back MODE, CTRL, BAUD and compare both the words and the held structs
	task automatic verify_regs();
		logic [31:0] v;
		bus_read(4'h8, joy_pkg::access_16bit, v);
		check_word("JOY_MODE", v, mode_w);
		check_mode("mode", joy_io_top_inst.mode, mode_from_word(mode_w));
		bus_read(4'hA, joy_pkg::access_16bit, v);
		check_word("JOY_CTRL", v, ctrl_w);
		check_ctrl("ctrl_q", joy_io_top_inst.joy_regs_inst.ctrl_q, ctrl_from_word(ctrl_w));
		bus_read(4'hE, joy_pkg::access_16bit, v);
		check_word("JOY_BAUD", v, {16'h0, baud_w});
	endtask

	task automatic poll_stat(input int bit_n, output logic [31:0] v);
		int i;
		for (i = 0; i < POLL_LIMIT; i++) begin
			bus_read(4'h4, joy_pkg::access_32bit, v);
			if (v[bit_n]) begin
				break;
			end
		end
		if (i == POLL_LIMIT) begin
			abort_run($sformatf("Timeout waiting for JOY_STAT bit %0d", bit_n));
		end
	endtask

	task automatic send_byte(input logic [7:0] data);
		logic [31:0]           v;
		joy_pkg::joy_tx_item_t item;
		poll_stat(0, v); // TX ready
		bus_write(4'h0, joy_pkg::access_32bit, {$urandom} << 8 | data);
		if (ctrl_w[0] && !ctrl_w[1]) begin
			item.slot = ctrl_w[13];
			item.data = data;
			exp_q.push_back(item);
			fin_m = 1'b0;
		end
	endtask

	// TX write that must be dropped, ready must stay high right after it
	task automatic blocked_write(input int kind);
		logic [31:0] v;
		case (kind)
			0:       write_ctrl(32'h3); // Select set
			1:       write_ctrl(32'h0); // TX disabled
			default: write_ctrl(32'h1);
		endcase
		bus_write(4'h0, (kind == 2) ? joy_pkg::access_16bit : joy_pkg::access_32bit, $urandom);
		bus_read(4'h4, joy_pkg::access_32bit, v);
		check_word("JOY_STAT tx ready", v & 32'h1, 32'h1);
	endtask

	// Wait for every queued byte on the port, then fold the answers into the model
	task automatic drain();
		joy_pkg::joy_tx_item_t item;
		logic [31:0]           v;
		logic [7:0]            answer;
		int                    total;
		int                    t;
		total = seen + exp_q.size();
		for (t = 0; t < 1000 * (total - seen) + 100 && pad_count != total; t++) begin
			@(posedge clk);
			#1;
		end
		if (pad_count != total) begin
			abort_run("Timeout waiting for bytes on the port");
		end
		for (t = 0; t < POLL_LIMIT && port_sel != 2'b00; t++) begin
			@(posedge clk);
			#1;
		end
		if (port_sel != 2'b00) begin
			abort_run("Timeout waiting for port select to drop");
		end
		poll_stat(2, v); // TX finished
		for (int i = seen; i < total; i++) begin
			item = exp_q.pop_front();
			check_byte("o_port_txd byte", pad_inst.log_byte[i], item.data);
			check_byte("o_port_sel", {6'd0, pad_inst.log_sel[i]}, {6'd0, 2'b01 << item.slot});
			answer = ~item.data ^ (item.slot ? 8'h5A : 8'h00);
			hist_m = {hist_m[23:0], answer};
			fin_m  = 1'b1;
			pend_m = 1'b1;
			if (ctrl_w[10]) begin
				irq_m = 1'b1;
			end
		end
		seen = total;
	endtask

	// STAT, RX history and interrupt line against the model
	task automatic check_status();
		logic [31:0] v;
		bus_read(4'h4, joy_pkg::access_32bit, v);
		check_word("JOY_STAT", v, {22'h0, irq_m, 6'h0, fin_m, pend_m, 1'b1});
		bus_read(4'h0, joy_pkg::access_32bit, v);
		check_word("JOY_RX_DATA", v, hist_m);
		pend_m = 1'b0; // Cleared by the RX read
		check_byte("o_int7", {7'd0, int7}, {7'd0, irq_m});
		check_byte("o_bad_access", {7'd0, bad}, {7'd0, bad_m});
	endtask

	// Small baud setting, factor x1 or x16
	task automatic configure_port();
		logic [1:0] code;
		code = $urandom % 3;
		write_mode({30'h0, code});
		write_baud((code == 2'd2) ? 1 + $urandom % 2 : 1 + $urandom % 6);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		seed_val = $urandom(SEED);
		clk      = 1'b0;
		rst      = 1'b1;
		bus      = '0;
		seen     = 0;
		model_reset();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_byte("o_port_clk", {7'd0, port_clk}, 8'h01);
		check_byte("o_port_sel", {6'd0, port_sel}, 8'h00);
		check_status();

		// Register write and read back
		for (int n = 0; n < 8; n++) begin
			write_mode($urandom);
			write_ctrl($urandom & ~32'h50); // No IRQ clear, no soft reset
			write_baud($urandom);
			verify_regs();
		end
		check_byte("o_bad_access", {7'd0, bad}, 8'h00);

		// Single transfers with blocked writes and IRQ
		configure_port();
		for (int n = 0; n < 12; n++) begin
			if ($urandom % 3 == 0) begin
				blocked_write($urandom % 3);
			end
			write_ctrl(($urandom & 32'h1B2C) | ($urandom % 2) << 13 | ($urandom % 2) << 10 | 32'h1);
			send_byte($urandom);
			drain();
			check_status();
			if (irq_m) begin
				write_ctrl(ctrl_w | 32'h10);
				check_byte("o_int7 after clear", {7'd0, int7}, 8'h00);
			end
		end

		// Bursts past the queue depth, slot varies per byte
		for (int b = 0; b < 3; b++) begin
			configure_port();
			for (int n = 0; n < TXQ_DEPTH + 4; n++) begin
				write_ctrl(($urandom % 2) << 13 | 32'h1);
				send_byte($urandom);
			end
			drain();
			check_status();
		end

		// Forbidden accesses, then soft reset
		for (int n = 0; n < 8; n++) begin
			write_mode($urandom);
			write_baud($urandom);
			write_ctrl($urandom & ~32'h50);
			case ($urandom % 5)
				0:       bus_read(4'h2, joy_pkg::access_16bit, w); // Word 1
				1:       bus_read(4'h6, joy_pkg::access_16bit, w); // Word 3
				2:       bus_read(4'h8, joy_pkg::access_32bit, w);
				3:       bus_read(4'hA, joy_pkg::access_32bit, w);
				default: bus_read(4'h4, joy_pkg::access_8bit, w);  // 8 bit off byte 0
			endcase
			bad_m = 1'b1;
			check_byte("o_bad_access", {7'd0, bad}, 8'h01);
			write_ctrl(32'h40 | $urandom & 32'h3F2F);
			verify_regs();
			check_status();
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: tb_joy_pad.sv
// Behavioral two-slot controller model that answers each byte with its inverse, slot 1 XOR 8'h5A
`timescale 1ns/1ps

module tb_joy_pad (
	input  logic       i_port_clk,
	input  logic [1:0] i_port_sel,
	input  logic       i_port_txd,
	output logic [1:0] o_port_rxd,
	output int         o_count     // Bytes seen so far
);

	logic [7:0] log_byte [0:255]; // Received bytes in arrival order
	logic [1:0] log_sel  [0:255]; // Select seen, 2'b11 if it moved mid byte
	logic [7:0] shift;
	logic [1:0] cur_sel;
	logic [7:0] mask;
	int         nbit;

	initial begin
		o_port_rxd = 2'b11;
		o_count    = 0;
		nbit       = 0;
		shift      = 8'h00;
		cur_sel    = 2'b00;
	end

	// Answer bit goes out shortly after the fall, once txd has settled
	always @(negedge i_port_clk) begin
		#1;
		mask       = i_port_sel[1] ? 8'h5A : 8'h00;
		o_port_rxd = 2'b11;
		for (int s = 0; s < 2; s++) begin
			if (i_port_sel[s]) begin
				o_port_rxd[s] = ~i_port_txd ^ mask[nbit];
			end
		end
	end

	// Sample on the rise, LSB first
	always @(posedge i_port_clk) begin
		if (|i_port_sel) begin
			shift = {i_port_txd, shift[7:1]};
			if (nbit == 0) begin
				cur_sel = i_port_sel;
			end else if (i_port_sel != cur_sel) begin
				cur_sel = 2'b11; // Select changed inside the byte
			end
			if (nbit == 7) begin
				log_byte[o_count] = shift;
				log_sel[o_count]  = cur_sel;
				o_count           = o_count + 1;
				nbit              = 0;
			end else begin
				nbit = nbit + 1;
			end
		end
	end

endmodule
